/* exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// datapath width of the execute slice
`define EXEC_DW 32

// general register file size
`define EXEC_NREGS 8

// bits needed to index one register
`define EXEC_RW 3

// EXEC_NREGS must be 2**EXEC_RW

`endif

/* exec_pkg.sv */
`default_nettype none

`include "exec_config.svh"

package exec_pkg;

    typedef enum logic [3:0] {
        ALU_MOVE,  // dst = src/imm
        ALU_ADD,
        ALU_ADC,   // add with carry in
        ALU_SUB,
        ALU_SBC,   // sub with borrow in
        ALU_AND,
        ALU_OR,
        ALU_MDEC1, // modulo decrement by 1
        ALU_MDEC2,
        ALU_MDEC4,
        ALU_BIT,   // test bit, z only
        ALU_BS1F,  // lowest set bit index
        ALU_BS1B,  // highest set bit index
        ALU_CCF,   // complement carry
        ALU_CHG,   // flip one bit of dst
        ALU_CPL    // one's complement
    } alu_op_e;

    typedef enum logic [1:0] {
        W_NONE, // flags only, no register write
        W_BYTE,
        W_WORD,
        W_LONG
    } op_width_e;

    typedef union packed {
        logic [`EXEC_DW-1:0] data; // plain operand
        struct packed {
            logic [`EXEC_DW-5:0] unused;
            logic [3:0]          idx;  // bit number for BIT/CHG
        } bit_sel;
    } imm_word_u;

    typedef struct packed {
        logic s; // sign
        logic z; // zero
        logic h; // half carry
        logic v; // overflow or parity
        logic n; // last op was a subtract
        logic c; // carry/borrow
    } alu_flags_t;

    typedef struct packed {
        alu_op_e             op;
        op_width_e           width;
        logic                sel_imm; // second operand from imm
        logic                flag_we; // flag update with width NONE
        logic [`EXEC_RW-1:0] dst;
        logic [`EXEC_RW-1:0] src;
        imm_word_u           imm;
    } exec_cmd_t;

    typedef struct packed {
        exec_cmd_t           cmd;
        logic [`EXEC_DW-1:0] op0; // read from dst
        logic [`EXEC_DW-1:0] op1; // read from src
    } exec_opnd_t;

    typedef struct packed {
        logic [`EXEC_RW-1:0] dst;
        op_width_e           width;
        logic [`EXEC_DW-1:0] data;  // full register image
        alu_flags_t          flags;
    } exec_rslt_t;

endpackage

`default_nettype wire

/* cmd_capture.sv */
`default_nettype none

module cmd_capture (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  in_req,
    input  exec_pkg::exec_cmd_t  in_cmd,
    output logic                 in_ack,
    output logic                 c_valid,
    output exec_pkg::exec_cmd_t  c_cmd,
    input  wire                  c_stall
);

    logic load; // take one command this edge

    // in_ack doubles as the phase bit of the handshake
    // low while waiting for req and high until req drops
    assign load = !in_ack && in_req && !c_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ack  <= 1'b0;
            c_valid <= 1'b0;
        end else begin
            if (c_valid && !c_stall) begin
                c_valid <= 1'b0;          // handed to reg read
            end
            if (load) begin
                in_ack  <= 1'b1;          // phase 2
                c_valid <= 1'b1;
            end else if (in_ack && !in_req) begin
                in_ack  <= 1'b0;          // phase 4, ready again
            end
        end
    end

    // command payload, only written on load
    always_ff @(posedge clk) begin
        if (load) begin
            c_cmd <= in_cmd;
        end
    end

endmodule

`default_nettype wire

/* reg_read_stage.sv */
`default_nettype none

`include "exec_config.svh"

module reg_read_stage (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  c_valid,
    input  exec_pkg::exec_cmd_t  c_cmd,
    output logic                 c_stall,
    output logic                 r_valid,
    output exec_pkg::exec_opnd_t r_opnd,
    input  wire                  r_stall,
    input  wire [`EXEC_RW-1:0]   a_busy_dst,
    input  wire                  a_busy,
    input  wire [`EXEC_RW-1:0]   p_busy_dst,
    input  wire                  p_busy,
    input  wire                  wb_en,
    input  wire [`EXEC_RW-1:0]   wb_dst,
    input  wire [`EXEC_DW-1:0]   wb_data
);

    logic [`EXEC_DW-1:0] regs [`EXEC_NREGS]; // general registers
    logic                hazard;              // pending write to src or dst
    logic                take;                // move command into r_opnd

    // true when a busy slot writes a register this command touches
    function automatic logic dst_hit(
        input logic                busy,
        input logic [`EXEC_RW-1:0] busy_dst,
        input exec_pkg::exec_cmd_t cmd
    );
        return busy && (busy_dst == cmd.dst || busy_dst == cmd.src);
    endfunction

    // three slots ahead of us may still owe a write-back
    assign hazard = dst_hit(r_valid, r_opnd.cmd.dst, c_cmd) ||
                    dst_hit(a_busy, a_busy_dst, c_cmd) ||
                    dst_hit(p_busy, p_busy_dst, c_cmd);

    assign c_stall = hazard || (r_valid && r_stall);
    assign take    = c_valid && !c_stall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            r_valid <= 1'b0;
        end else if (take) begin
            r_valid <= 1'b1;
        end else if (!r_stall) begin
            r_valid <= 1'b0;         // alu took it, nothing new
        end
    end

    // operand capture, no hazard so regs are current
    always_ff @(posedge clk) begin
        if (take) begin
            r_opnd.cmd <= c_cmd;
            r_opnd.op0 <= regs[c_cmd.dst];
            r_opnd.op1 <= regs[c_cmd.src];
        end
    end

    // write-back port
    // byte/word results come with the dst upper bits already merged by the alu,
    // so a full word write keeps them
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `EXEC_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_dst] <= wb_data;
        end
    end

endmodule

`default_nettype wire

/* alu_stage.sv */
`default_nettype none

`include "exec_config.svh"

module alu_stage (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  r_valid,
    input  exec_pkg::exec_opnd_t r_opnd,
    output logic                 r_stall,
    output logic                 a_valid,
    output exec_pkg::exec_rslt_t a_rslt,
    input  wire                  a_stall,
    output logic [`EXEC_RW-1:0]  a_busy_dst,
    output logic                 a_busy
);

    exec_pkg::op_width_e  w;         // operation width
    exec_pkg::alu_op_e    op;
    logic [`EXEC_DW-1:0]  op0, op1, op2; // dst, src, src or imm
    logic [3:0]           bidx;      // bit index from imm
    logic [`EXEC_DW-1:0]  res;       // raw result
    logic [`EXEC_DW-1:0]  merged;    // result placed into dst image
    logic [`EXEC_DW:0]    ext_res;   // sign extended sum for v
    logic [2:0]           cc;        // carry out of byte, word, long
    logic                 hc;        // nibble carry
    logic                 cin;       // carry/borrow in for ADC/SBC
    exec_pkg::alu_flags_t flags;     // persistent flag register
    exec_pkg::alu_flags_t nx;        // flags as the op leaves them
    exec_pkg::alu_flags_t flags_next;
    logic                 upd;       // op touches the flags
    logic                 load;      // accept r_opnd this edge

    function automatic logic sgn_at(input exec_pkg::op_width_e wd,
                                    input logic [`EXEC_DW-1:0] x);
        case (wd)
            exec_pkg::W_BYTE: return x[7];
            exec_pkg::W_WORD: return x[15];
            default:          return x[31];
        endcase
    endfunction

    function automatic logic zero_at(input exec_pkg::op_width_e wd,
                                     input logic [`EXEC_DW-1:0] x);
        case (wd)
            exec_pkg::W_BYTE: return x[7:0] == '0;
            exec_pkg::W_WORD: return x[15:0] == '0;
            default:          return x == '0;
        endcase
    endfunction

    function automatic logic [`EXEC_DW:0] sext(input exec_pkg::op_width_e wd,
                                               input logic [`EXEC_DW-1:0] x);
        case (wd)
            exec_pkg::W_BYTE: return {{25{x[7]}}, x[7:0]};
            exec_pkg::W_WORD: return {{17{x[15]}}, x[15:0]};
            default:          return {x[31], x};
        endcase
    endfunction

    assign w    = r_opnd.cmd.width;
    assign op   = r_opnd.cmd.op;
    assign op0  = r_opnd.op0;
    assign op1  = r_opnd.op1;
    assign op2  = r_opnd.cmd.sel_imm ? r_opnd.cmd.imm.data : r_opnd.op1;
    assign bidx = r_opnd.cmd.imm.bit_sel.idx;
    assign cin  = (op == exec_pkg::ALU_ADC || op == exec_pkg::ALU_SBC) ? flags.c : 1'b0;

    always_comb begin
        res     = op0;   // ops without data result leave dst alone
        nx      = flags;
        cc      = '0;
        hc      = 1'b0;
        ext_res = '0;
        case (op)
            exec_pkg::ALU_MOVE: res = op2;
            exec_pkg::ALU_ADD, exec_pkg::ALU_ADC: begin
                {hc, res[3:0]}       = {1'b0, op0[3:0]} + {1'b0, op2[3:0]} + {4'd0, cin};
                {cc[0], res[7:4]}    = {1'b0, op0[7:4]} + {1'b0, op2[7:4]} + {4'd0, hc};
                {cc[1], res[15:8]}   = {1'b0, op0[15:8]} + {1'b0, op2[15:8]} + {8'd0, cc[0]};
                {cc[2], res[31:16]}  = {1'b0, op0[31:16]} + {1'b0, op2[31:16]} + {16'd0, cc[1]};
                ext_res = sext(w, op0) + sext(w, op2) + {32'd0, cin};
                nx.n    = 1'b0;
            end
            exec_pkg::ALU_SUB, exec_pkg::ALU_SBC: begin
                {hc, res[3:0]}       = {1'b0, op0[3:0]} - {1'b0, op2[3:0]} - {4'd0, cin};
                {cc[0], res[7:4]}    = {1'b0, op0[7:4]} - {1'b0, op2[7:4]} - {4'd0, hc};
                {cc[1], res[15:8]}   = {1'b0, op0[15:8]} - {1'b0, op2[15:8]} - {8'd0, cc[0]};
                {cc[2], res[31:16]}  = {1'b0, op0[31:16]} - {1'b0, op2[31:16]} - {16'd0, cc[1]};
                ext_res = sext(w, op0) - sext(w, op2) - {32'd0, cin};
                nx.n    = 1'b1;
            end
            exec_pkg::ALU_AND: begin
                res  = op0 & op2;
                nx.h = 1'b1;
            end
            exec_pkg::ALU_OR: begin
                res  = op0 | op2;
                nx.h = 1'b0;
            end
            exec_pkg::ALU_MDEC1, exec_pkg::ALU_MDEC2, exec_pkg::ALU_MDEC4: begin
                if ((op0[15:0] & op2[15:0]) == '0) begin
                    res[15:0] = op0[15:0] + op2[15:0]; // wrap to top of window
                end else if (op == exec_pkg::ALU_MDEC1) begin
                    res[15:0] = op0[15:0] - 16'd1;
                end else if (op == exec_pkg::ALU_MDEC2) begin
                    res[15:0] = op0[15:0] - 16'd2;
                end else begin
                    res[15:0] = op0[15:0] - 16'd4;
                end
            end
            exec_pkg::ALU_BIT: begin
                nx.z = ~op1[bidx];
                nx.h = 1'b1;
                nx.n = 1'b0;
            end
            exec_pkg::ALU_CHG: res[bidx] = ~op0[bidx];
            exec_pkg::ALU_BS1F: begin
                res = '0;
                for (int i = 15; i >= 0; i--) begin
                    if (op1[i]) res = `EXEC_DW'(i); // last hit is lowest
                end
                nx.v = op1[15:0] == '0;
            end
            exec_pkg::ALU_BS1B: begin
                res = '0;
                for (int i = 0; i < 16; i++) begin
                    if (op1[i]) res = `EXEC_DW'(i); // last hit is highest
                end
                nx.v = op1[15:0] == '0;
            end
            exec_pkg::ALU_CCF: begin
                nx.c = ~flags.c;
                nx.n = 1'b0;
            end
            default: begin // ALU_CPL
                res  = ~op2;
                nx.h = 1'b1;
                nx.n = 1'b1;
            end
        endcase
        // shared flag rules by op group
        if (op inside {exec_pkg::ALU_ADD, exec_pkg::ALU_ADC,
                       exec_pkg::ALU_SUB, exec_pkg::ALU_SBC}) begin
            nx.s = sgn_at(w, res);
            nx.z = zero_at(w, res);
            nx.h = hc;
            nx.v = ext_res[`EXEC_DW] ^ sgn_at(w, res); // sign out of range
            nx.c = (w == exec_pkg::W_BYTE) ? cc[0] : (w == exec_pkg::W_WORD) ? cc[1] : cc[2];
        end else if (op == exec_pkg::ALU_AND || op == exec_pkg::ALU_OR) begin
            nx.s = sgn_at(w, res);
            nx.z = zero_at(w, res);
            nx.v = (w == exec_pkg::W_BYTE) ? ~^res[7:0] : ~^res[15:0]; // even parity
            nx.n = 1'b0;
            nx.c = 1'b0;
        end
    end

    // narrow ops keep the dst bits above their width
    always_comb begin
        case (w)
            exec_pkg::W_BYTE: merged = {op0[31:8], res[7:0]};
            exec_pkg::W_WORD: merged = {op0[31:16], res[15:0]};
            exec_pkg::W_LONG: merged = res;
            default:          merged = op0;   // no write
        endcase
    end

    assign upd        = (w != exec_pkg::W_NONE) || r_opnd.cmd.flag_we;
    assign flags_next = upd ? nx : flags;
    assign r_stall    = a_valid && a_stall;
    assign load       = r_valid && !r_stall;
    assign a_busy     = a_valid;
    assign a_busy_dst = a_rslt.dst;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_valid <= 1'b0;
            flags   <= '0;
        end else if (load) begin
            a_valid <= 1'b1;
            flags   <= flags_next; // same edge as the result
        end else if (!a_stall) begin
            a_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            a_rslt.dst   <= r_opnd.cmd.dst;
            a_rslt.width <= w;
            a_rslt.data  <= merged;
            a_rslt.flags <= flags_next;
        end
    end

endmodule

`default_nettype wire

/* result_port.sv */
`default_nettype none

`include "exec_config.svh"

module result_port (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  a_valid,
    input  exec_pkg::exec_rslt_t a_rslt,
    output logic                 a_stall,
    output logic                 out_req,
    output exec_pkg::exec_rslt_t out_rslt,
    input  wire                  out_ack,
    output logic                 wb_en,
    output logic [`EXEC_RW-1:0]  wb_dst,
    output logic [`EXEC_DW-1:0]  wb_data,
    output logic [`EXEC_RW-1:0]  p_busy_dst,
    output logic                 p_busy
);

    localparam logic [1:0] ST_EMPTY = 2'd0; // slot free
    localparam logic [1:0] ST_HOLD  = 2'd1; // result taken, req next
    localparam logic [1:0] ST_REQ   = 2'd2; // req high, wait ack
    localparam logic [1:0] ST_DONE  = 2'd3; // req low, wait ack low

    logic [1:0] state;

    assign a_stall    = state != ST_EMPTY;
    assign p_busy     = state != ST_EMPTY;   // dst still owed to reg file
    assign p_busy_dst = out_rslt.dst;
    assign wb_dst     = out_rslt.dst;
    assign wb_data    = out_rslt.data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_EMPTY;
            out_req <= 1'b0;
            wb_en   <= 1'b0;
        end else begin
            wb_en <= 1'b0;               // one cycle pulse
            case (state)
                ST_EMPTY: if (a_valid) state <= ST_HOLD;
                ST_HOLD: begin
                    out_req <= 1'b1;
                    wb_en   <= out_rslt.width != exec_pkg::W_NONE;
                    state   <= ST_REQ;
                end
                ST_REQ: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= ST_DONE;
                    end
                end
                default: if (!out_ack) state <= ST_EMPTY; // ST_DONE
            endcase
        end
    end

    // held stable through the whole ack cycle
    always_ff @(posedge clk) begin
        if (state == ST_EMPTY && a_valid) begin
            out_rslt <= a_rslt;
        end
    end

endmodule

`default_nettype wire

/* exec_unit.sv */
`default_nettype none

`include "exec_config.svh"

module exec_unit (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  in_req,
    input  exec_pkg::exec_cmd_t  in_cmd,
    output logic                 in_ack,
    output logic                 out_req,
    output exec_pkg::exec_rslt_t out_rslt,
    input  wire                  out_ack
);

    logic                 c_valid, c_stall;   // capture -> reg read
    exec_pkg::exec_cmd_t  c_cmd;
    logic                 r_valid, r_stall;   // reg read -> alu
    exec_pkg::exec_opnd_t r_opnd;
    logic                 a_valid, a_stall;   // alu -> result port
    exec_pkg::exec_rslt_t a_rslt;
    logic [`EXEC_RW-1:0]  a_busy_dst, p_busy_dst; // hazard taps
    logic                 a_busy, p_busy;
    logic                 wb_en;              // write-back
    logic [`EXEC_RW-1:0]  wb_dst;
    logic [`EXEC_DW-1:0]  wb_data;

    cmd_capture u_cap (
        .clk, .rst, .in_req, .in_cmd, .in_ack,
        .c_valid, .c_cmd, .c_stall
    );

    reg_read_stage u_rd (
        .clk, .rst, .c_valid, .c_cmd, .c_stall,
        .r_valid, .r_opnd, .r_stall,
        .a_busy_dst, .a_busy, .p_busy_dst, .p_busy,
        .wb_en, .wb_dst, .wb_data
    );

    alu_stage u_alu (
        .clk, .rst, .r_valid, .r_opnd, .r_stall,
        .a_valid, .a_rslt, .a_stall, .a_busy_dst, .a_busy
    );

    result_port u_out (
        .clk, .rst, .a_valid, .a_rslt, .a_stall,
        .out_req, .out_rslt, .out_ack,
        .wb_en, .wb_dst, .wb_data, .p_busy_dst, .p_busy
    );

endmodule

`default_nettype wire

/* exec_unit_assert.sv */
`default_nettype none

module exec_unit_assert (
    input wire                  clk,
    input wire                  rst,
    input wire                  in_req,
    input wire                  in_ack,
    input wire                  out_req,
    input wire                  out_ack,
    input exec_pkg::exec_rslt_t out_rslt,
    input wire                  c_valid,
    input wire                  r_valid,
    input wire                  a_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;                         // read by the testbench at the end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(in_ack) |-> $past(in_req))
        else begin
            failures++;
            $error("in_ack rose without in_req");
        end

    // payload frozen while the sink has not answered
    req_held: assert property (@(posedge clk) disable iff (rst)
        out_req && !out_ack |=> out_req && $stable(out_rslt))
        else begin
            failures++;
            $error("out_req or out_rslt moved before out_ack");
        end

    reset_clean: assert property (@(posedge clk)
        $fell(rst) |-> !c_valid && !r_valid && !a_valid && !in_ack && !out_req)
        else begin
            failures++;
            $error("pipeline not empty after reset");
        end

endmodule

bind exec_unit exec_unit_assert u_assert (
    .clk, .rst, .in_req, .in_ack, .out_req, .out_ack, .out_rslt,
    .c_valid, .r_valid, .a_valid
);

`default_nettype wire

/* exec_unit_tb.sv */
`default_nettype none

`include "exec_config.svh"

module exec_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM = 30;                  // table rows

    logic                 clk;
    logic                 rst;
    logic                 in_req;
    exec_pkg::exec_cmd_t  in_cmd;
    logic                 in_ack;
    logic                 out_req;
    exec_pkg::exec_rslt_t out_rslt;
    logic                 out_ack;

    exec_pkg::exec_cmd_t  cmd_tab  [NUM];     // commands in issue order
    logic [`EXEC_DW-1:0]  data_tab [NUM];     // expected register image
    exec_pkg::alu_flags_t flag_tab [NUM];     // expected s z h v n c
    int                   n_cmds;
    int                   held_cycles;        // cycles with req up and ack withheld
    logic [31:0]          lfsr;

    exec_unit u_dut (
        .clk, .rst, .in_req, .in_cmd, .in_ack,
        .out_req, .out_rslt, .out_ack
    );

    always #50 clk = ~clk;

    task automatic stop_on_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_data(input logic [`EXEC_DW-1:0] got, input logic [`EXEC_DW-1:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t out_rslt.data got %h expected %h", $time, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flags(input exec_pkg::alu_flags_t got, input exec_pkg::alu_flags_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t out_rslt.flags got %b expected %b", $time, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_dst(input logic [`EXEC_RW-1:0] got, input logic [`EXEC_RW-1:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t out_rslt.dst got %0d expected %0d", $time, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_width(input exec_pkg::op_width_e got, input exec_pkg::op_width_e exp);
        if (got !== exp) begin
            $display("ERROR t=%0t out_rslt.width got %0d expected %0d", $time, got, exp);
            stop_on_failure();
        end
    endtask

    // fibonacci form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic add_cmd(input exec_pkg::alu_op_e op, input exec_pkg::op_width_e wd,
                           input logic sel, input logic [`EXEC_RW-1:0] dst,
                           input logic [`EXEC_RW-1:0] src, input logic [31:0] imm,
                           input logic [`EXEC_DW-1:0] exp_data,
                           input exec_pkg::alu_flags_t exp_flags);
        exec_pkg::exec_cmd_t c;
        c.op       = op;
        c.width    = wd;
        c.sel_imm  = sel;
        c.flag_we  = wd == exec_pkg::W_NONE;  // flag-only ops still set flags
        c.dst      = dst;
        c.src      = src;
        c.imm.data = imm;
        cmd_tab[n_cmds]  = c;
        data_tab[n_cmds] = exp_data;
        flag_tab[n_cmds] = exp_flags;
        n_cmds++;
    endtask

    // op, width, sel_imm, dst, src, imm, data, flags szhvnc
    task automatic load_table();
        add_cmd(exec_pkg::ALU_MOVE, exec_pkg::W_LONG, 1, 1, 0, 'h12345678, 'h12345678, 'b000000);
        add_cmd(exec_pkg::ALU_MOVE, exec_pkg::W_BYTE, 1, 1, 0, 'hAB, 'h123456AB, 'b000000);
        add_cmd(exec_pkg::ALU_MOVE, exec_pkg::W_WORD, 1, 1, 0, 'hCDEF, 'h1234CDEF, 'b000000);
        add_cmd(exec_pkg::ALU_MOVE, exec_pkg::W_LONG, 0, 2, 1, 'h0, 'h1234CDEF, 'b000000);
        add_cmd(exec_pkg::ALU_MOVE, exec_pkg::W_LONG, 1, 3, 0, 'hF0, 'hF0, 'b000000);
        add_cmd(exec_pkg::ALU_ADD, exec_pkg::W_BYTE, 1, 3, 0, 'h20, 'h10, 'b000001);
        add_cmd(exec_pkg::ALU_ADC, exec_pkg::W_BYTE, 1, 3, 0, 'h0F, 'h20, 'b001000);
        add_cmd(exec_pkg::ALU_SUB, exec_pkg::W_WORD, 1, 3, 0, 'h21, 'hFFFF, 'b101011);
        add_cmd(exec_pkg::ALU_SBC, exec_pkg::W_WORD, 1, 3, 0, 'h7FFF, 'h7FFF, 'b001110);
        add_cmd(exec_pkg::ALU_ADD, exec_pkg::W_LONG, 1, 3, 0, 'h7FFF8001, 'h80000000, 'b101100);
        add_cmd(exec_pkg::ALU_ADD, exec_pkg::W_LONG, 1, 3, 0, 'h80000000, 'h0, 'b010101);
        add_cmd(exec_pkg::ALU_SBC, exec_pkg::W_BYTE, 1, 3, 0, 'h01, 'hFE, 'b101011);
        add_cmd(exec_pkg::ALU_MOVE, exec_pkg::W_LONG, 1, 4, 0, 'hF0F0A5C3, 'hF0F0A5C3, 'b101011);
        add_cmd(exec_pkg::ALU_AND, exec_pkg::W_WORD, 1, 4, 0, 'hFF0F, 'hF0F0A503, 'b101100);
        add_cmd(exec_pkg::ALU_OR, exec_pkg::W_BYTE, 1, 4, 0, 'h08, 'hF0F0A50B, 'b000000);
        add_cmd(exec_pkg::ALU_CPL, exec_pkg::W_LONG, 0, 4, 4, 'h0, 'h0F0F5AF4, 'b001010);
        add_cmd(exec_pkg::ALU_CCF, exec_pkg::W_NONE, 0, 4, 0, 'h0, 'h0F0F5AF4, 'b001001);
        add_cmd(exec_pkg::ALU_CCF, exec_pkg::W_NONE, 0, 4, 0, 'h0, 'h0F0F5AF4, 'b001000);
        add_cmd(exec_pkg::ALU_MOVE, exec_pkg::W_LONG, 1, 5, 0, 'h10, 'h10, 'b001000);
        add_cmd(exec_pkg::ALU_MDEC2, exec_pkg::W_LONG, 1, 5, 0, 'h0E, 'h1E, 'b001000);
        add_cmd(exec_pkg::ALU_MDEC1, exec_pkg::W_WORD, 1, 5, 0, 'h0E, 'h1D, 'b001000);
        add_cmd(exec_pkg::ALU_MDEC4, exec_pkg::W_LONG, 1, 5, 0, 'h0C, 'h19, 'b001000);
        add_cmd(exec_pkg::ALU_BIT, exec_pkg::W_NONE, 0, 4, 4, 'h3, 'h0F0F5AF4, 'b011000);
        add_cmd(exec_pkg::ALU_CHG, exec_pkg::W_LONG, 0, 4, 0, 'h3, 'h0F0F5AFC, 'b011000);
        add_cmd(exec_pkg::ALU_BIT, exec_pkg::W_NONE, 0, 4, 4, 'h3, 'h0F0F5AFC, 'b001000);
        add_cmd(exec_pkg::ALU_BIT, exec_pkg::W_NONE, 0, 4, 4, 'h0, 'h0F0F5AFC, 'b001000);
        cmd_tab[n_cmds-1].flag_we = 1'b0;     // z holds with the flag write off
        add_cmd(exec_pkg::ALU_BS1F, exec_pkg::W_LONG, 0, 6, 4, 'h0, 'h2, 'b001000);
        add_cmd(exec_pkg::ALU_BS1B, exec_pkg::W_LONG, 0, 6, 4, 'h0, 'hE, 'b001000);
        add_cmd(exec_pkg::ALU_BS1F, exec_pkg::W_WORD, 0, 7, 0, 'h0, 'h0, 'b001100);
        add_cmd(exec_pkg::ALU_MOVE, exec_pkg::W_LONG, 0, 0, 3, 'h0, 'hFE, 'b001100);
    endtask

    // producer side of the input handshake with one row per req/ack cycle
    task automatic send_cmds();
        for (int i = 0; i < NUM; i++) begin
            in_cmd = cmd_tab[i];
            in_req = 1'b1;
            @(posedge clk);
            #5;
            while (!in_ack) begin
                held_cycles++;                // capture slot still full
                @(posedge clk);
                #5;
            end
            in_req = 1'b0;
            while (in_ack) begin
                @(posedge clk);
                #5;
            end
        end
    endtask

    // sink side with a random ack delay of 0 to 3 cycles
    task automatic take_results();
        logic [1:0] delay;
        for (int i = 0; i < NUM; i++) begin
            while (!out_req) begin
                @(posedge clk);
                #5;
            end
            check_dst(out_rslt.dst, cmd_tab[i].dst);
            check_width(out_rslt.width, cmd_tab[i].width);
            check_data(out_rslt.data, data_tab[i]);
            check_flags(out_rslt.flags, flag_tab[i]);
            lfsr     = lfsr_step(lfsr);
            delay[0] = lfsr[0];
            lfsr     = lfsr_step(lfsr);
            delay[1] = lfsr[0];
            repeat (delay) begin
                @(posedge clk);
                #5;
            end
            out_ack = 1'b1;
            while (out_req) begin
                @(posedge clk);
                #5;
            end
            out_ack = 1'b0;
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        in_req      = 1'b0;
        in_cmd      = '0;
        out_ack     = 1'b0;
        lfsr        = 32'h2098;
        held_cycles = 0;
        n_cmds      = 0;
        load_table();
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;
        fork
            send_cmds();
            take_results();
        join
        repeat (4) @(posedge clk);            // pipeline should stay quiet
        #5;
        if (out_req) begin
            $display("an extra result came out after the last table row");
            stop_on_failure();
        end else if (held_cycles == 0) begin
            $display("in_ack was never withheld, so back-pressure was not exercised");
            stop_on_failure();
        end else if (u_dut.u_assert.failures != 0) begin
            $display("a bound handshake assertion failed during the run");
            stop_on_failure();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

    // worst case about 12 cycles per row
    initial begin
        #(NUM * 12 * 100);
        $display("watchdog timeout, results stopped arriving");
        stop_on_failure();
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
exec_pkg.sv
cmd_capture.sv
reg_read_stage.sv
alu_stage.sv
result_port.sv
exec_unit.sv
exec_unit_assert.sv
exec_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module exec_unit_tb \
    -f vlog.f -o exec_unit_sim \
    && ./obj_dir/exec_unit_sim > sim.log 2>&1 \
    || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log && echo "run passed" && exit 0 \
    || { echo "run failed"; exit 1; }
